// File: build.f
+incdir+common
+incdir+testbench
common/scalar_pkg.sv
hdl/pipe_stage.sv
fetch/fetch_unit.sv
decode/decode_unit.sv
execute/register_file.sv
execute/scalar_alu.sv
hdl/result_unit.sv
hdl/scalar_unit.sv
testbench/tb_scalar_unit.sv

// File: Makefile
# Verilator simulation of the scalar unit testbench

SIM := obj_dir/Vtb_scalar_unit
SOURCES := $(wildcard common/*.sv common/*.svh fetch/*.sv decode/*.sv \
	execute/*.sv hdl/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_scalar_unit -f build.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: testbench/scalar_model.svh
/*
 * Scalar unit reference model
 * Random program generators and an in-order architectural run
 * that yields the expected emits, vector commands, lanes and flags
 */

`ifndef SCALAR_MODEL_SVH
`define SCALAR_MODEL_SVH

localparam int MODEL_STEPS = 4000;

// Program under test and the expected results of running it
scalar_pkg::instr_t  prog [$];
logic [31:0]         exp_data [$];
logic [31:0]         exp_cmd [$];
scalar_pkg::lane_t   exp_lane;
scalar_pkg::status_t exp_state;

////////////////////////////////////////////////////////////
// Instruction encoding

function automatic scalar_pkg::instr_t alu_word(logic [3:0] op, logic [1:0] ds,
	logic [4:0] dst, logic [4:0] s1, logic [4:0] s2, logic [4:0] s3);
	return {1'b0, op, ds, dst, s1, s2, s3, 5'd0};
endfunction

// LDI value or branch target in the low 20 bits
function automatic scalar_pkg::instr_t const_word(logic [3:0] op, logic [1:0] ds,
	logic [4:0] dst, logic [19:0] k);
	return {1'b0, op, ds, dst, k};
endfunction

////////////////////////////////////////////////////////////
// Program generators

function automatic void gen_straight(int n_ops, int vec_pct, int lane_pct);
	logic [3:0]         op;
	logic [1:0]         ds;
	logic [4:0]         r;
	int                 pick;
	scalar_pkg::instr_t w;
	prog.delete();
	for (int i = 0; i < 6; i++) begin
		prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_REG,
			5'($urandom_range(0, 31)), 20'($urandom())));
	end
	for (int i = 0; i < n_ops; i++) begin
		if (int'($urandom_range(0, 99)) < vec_pct) begin
			w = $urandom();
			w.sel_unit = 1'b1;
			prog.push_back(w);
		end
		op   = 4'($urandom_range(0, 9));
		pick = int'($urandom_range(0, 99));
		if (pick < lane_pct) begin
			ds = scalar_pkg::DST_LANE;
		end else if (pick < lane_pct + 10) begin
			ds = scalar_pkg::DST_VEC;
		end else if (pick < lane_pct + 15) begin
			ds = scalar_pkg::DST_NONE;
		end else begin
			ds = scalar_pkg::DST_REG;
		end
		if (op == scalar_pkg::OP_LDI) begin
			prog.push_back(const_word(op, ds, 5'($urandom_range(0, 31)), 20'($urandom())));
		end else begin
			prog.push_back(alu_word(op, ds, 5'($urandom_range(0, 31)),
				5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
				5'($urandom_range(0, 31))));
		end
	end
	// Closing emits of random registers
	for (int i = 0; i < 4; i++) begin
		r = 5'($urandom_range(0, 31));
		prog.push_back(alu_word(scalar_pkg::OP_OR, scalar_pkg::DST_VEC, 5'd0, r, r, 5'd0));
	end
	prog.push_back(const_word(scalar_pkg::OP_HALT, scalar_pkg::DST_NONE, 5'd0, 20'd0));
endfunction

// r1 counts up by step until it reaches limit, emitting each value
function automatic void gen_loop(int limit, int step);
	prog.delete();
	prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_REG, 5'd1, 20'd0));
	prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_REG, 5'd2, 20'(limit)));
	prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_REG, 5'd3, 20'(step)));
	// Limit below zero is false, so this branch falls through
	prog.push_back(alu_word(scalar_pkg::OP_CMPLT, scalar_pkg::DST_NONE, 5'd0, 5'd2, 5'd1, 5'd0));
	prog.push_back(const_word(scalar_pkg::OP_BRC, scalar_pkg::DST_NONE, 5'd0, 20'd11));
	// Loop body at address 5
	prog.push_back(alu_word(scalar_pkg::OP_ADD, scalar_pkg::DST_REG, 5'd1, 5'd1, 5'd3, 5'd0));
	prog.push_back(alu_word(scalar_pkg::OP_OR, scalar_pkg::DST_VEC, 5'd0, 5'd1, 5'd1, 5'd0));
	prog.push_back(alu_word(scalar_pkg::OP_CMPLT, scalar_pkg::DST_REG, 5'd4, 5'd1, 5'd2, 5'd0));
	prog.push_back(const_word(scalar_pkg::OP_BRC, scalar_pkg::DST_NONE, 5'd0, 20'd5));
	prog.push_back(const_word(scalar_pkg::OP_JMP, scalar_pkg::DST_NONE, 5'd0, 20'd12));
	// Skipped emits
	prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_VEC, 5'd0, 20'hDEAD));
	prog.push_back(const_word(scalar_pkg::OP_LDI, scalar_pkg::DST_VEC, 5'd0, 20'hBEEF));
	prog.push_back(alu_word(scalar_pkg::OP_OR, scalar_pkg::DST_VEC, 5'd0, 5'd4, 5'd4, 5'd0));
	prog.push_back(const_word(scalar_pkg::OP_HALT, scalar_pkg::DST_NONE, 5'd0, 20'd0));
endfunction

////////////////////////////////////////////////////////////
// Architectural run that returns 1 once HALT is reached

function automatic bit run_model();
	scalar_pkg::data_t  regs [`SCALAR_NUM_REGS];
	scalar_pkg::instr_t w;
	scalar_pkg::data_t  a;
	scalar_pkg::data_t  b;
	scalar_pkg::data_t  c;
	scalar_pkg::data_t  k;
	scalar_pkg::data_t  v;
	int                 pc;
	exp_data.delete();
	exp_cmd.delete();
	exp_lane  = '0;
	exp_state = '0;
	for (int i = 0; i < `SCALAR_NUM_REGS; i++) begin
		regs[i] = '0;
	end
	pc = 0;
	for (int step = 0; step < MODEL_STEPS; step++) begin
		if (pc >= prog.size()) begin
			return 1'b0;
		end
		w  = prog[pc];
		a  = regs[w.src1];
		b  = regs[w.src2];
		c  = regs[w.src3];
		k  = {12'd0, w[19:0]};
		pc = pc + 1;
		if (w.sel_unit) begin
			exp_cmd.push_back(w);
		end else if (w.op == scalar_pkg::OP_HALT) begin
			return 1'b1;
		end else if (w.op == scalar_pkg::OP_JMP) begin
			pc = int'(k[5:0]);
		end else if (w.op == scalar_pkg::OP_BRC) begin
			if (exp_state.cond) begin
				pc = int'(k[5:0]);
			end
		end else begin
			case (w.op)
				scalar_pkg::OP_ADD:   v = a + b;
				scalar_pkg::OP_SUB:   v = a - b;
				scalar_pkg::OP_AND:   v = a & b;
				scalar_pkg::OP_OR:    v = a | b;
				scalar_pkg::OP_XOR:   v = a ^ b;
				scalar_pkg::OP_SHL:   v = a << b[4:0];
				scalar_pkg::OP_SHR:   v = a >> b[4:0];
				scalar_pkg::OP_MAD:   v = a * b + c;
				scalar_pkg::OP_LDI:   v = k;
				scalar_pkg::OP_CMPLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default:              v = '0;
			endcase
			exp_state.zero     = v == '0;
			exp_state.negative = v[`SCALAR_DATA_W-1];
			if (w.op == scalar_pkg::OP_CMPLT) begin
				exp_state.cond = v[0];
			end
			case (w.dst_sel)
				scalar_pkg::DST_REG:  regs[w.dst] = v;
				scalar_pkg::DST_LANE: exp_lane = v[`SCALAR_NUM_LANES-1:0];
				scalar_pkg::DST_VEC:  exp_data.push_back(v);
				default:              ;
			endcase
		end
	end
	return 1'b0;
endfunction

`endif

// File: testbench/tb_scalar_unit.sv
/*
 * Scalar unit testbench
 * Loads random and looping programs, runs them to HALT and
 * compares every output event with the architectural model
 */

`default_nettype none

`include "scalar_macros.svh"

module tb_scalar_unit;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 16;
	localparam int STRAIGHT_TESTS = 40;
	localparam int LOOP_TESTS     = 8;
	localparam int LANE_TESTS     = 8;
	localparam int VECTOR_TESTS   = 8;
	localparam int NUM_TESTS      = STRAIGHT_TESTS + LOOP_TESTS + LANE_TESTS + VECTOR_TESTS;
	localparam int TEST_CYCLES    = 2000;

	logic                clock;
	logic                reset;
	logic                en;
	logic                req_st;
	scalar_pkg::instr_t  instr_in;
	logic                ack_st;
	scalar_pkg::instr_t  v_command;
	logic                v_command_valid;
	scalar_pkg::data_t   scalar_data;
	logic                scalar_valid;
	scalar_pkg::lane_t   lane_en;
	scalar_pkg::status_t state;
	logic                term;

	logic [31:0] got_data [$];
	logic [31:0] got_cmd [$];
	logic        prev_req = 1'b0;
	logic        prev_reset = 1'b1;
	string       test_name = "reset";

	`include "scalar_model.svh"

	scalar_unit DUT (
		.clock           (clock),
		.reset           (reset),
		.en              (en),
		.req_st          (req_st),
		.instr_in        (instr_in),
		.ack_st          (ack_st),
		.v_command       (v_command),
		.v_command_valid (v_command_valid),
		.scalar_data     (scalar_data),
		.scalar_valid    (scalar_valid),
		.lane_en         (lane_en),
		.state           (state),
		.term            (term)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Reporting

	task automatic report_failure(string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			report_failure($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
				name, expected, actual));
		end
	endtask

	// Output events, ack timing and silence after term
	always @(negedge clock) begin
		if (!reset && !prev_reset) begin
			check({test_name, " ack_st"}, 32'(prev_req), 32'(ack_st));
			if (term && (scalar_valid || v_command_valid)) begin
				report_failure({test_name, ": output event seen after term"});
			end
			if (scalar_valid) begin
				got_data.push_back(scalar_data);
			end
			if (v_command_valid) begin
				got_cmd.push_back(v_command);
			end
		end
		prev_req   = req_st;
		prev_reset = reset;
	end

	////////////////////////////////////////////////////////////
	// Test sequencing

	task automatic apply_reset();
		@(posedge clock);
		reset  <= 1'b1;
		en     <= 1'b0;
		req_st <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check({test_name, " reset ack_st"}, 32'd0, 32'(ack_st));
		check({test_name, " reset v_command_valid"}, 32'd0, 32'(v_command_valid));
		check({test_name, " reset scalar_valid"}, 32'd0, 32'(scalar_valid));
		check({test_name, " reset term"}, 32'd0, 32'(term));
		check({test_name, " reset lane_en"}, 32'd0, 32'(lane_en));
		check({test_name, " reset state"}, 32'd0, 32'(state));
		got_data.delete();
		got_cmd.delete();
	endtask

	task automatic load_program();
		if (prog.size() > `SCALAR_IMEM_DEPTH) begin
			report_failure({test_name, ": program does not fit in instruction memory"});
		end
		foreach (prog[i]) begin
			@(posedge clock);
			req_st   <= 1'b1;
			instr_in <= prog[i];
			@(posedge clock);
			req_st <= 1'b0;
		end
	endtask

	task automatic run_program(string name);
		int cycles;
		test_name = name;
		if (!run_model()) begin
			report_failure({name, ": model never reached HALT"});
		end
		apply_reset();
		load_program();
		@(posedge clock);
		en <= 1'b1;
		cycles = 0;
		while (!term && cycles < TEST_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!term) begin
			report_failure($sformatf("%s: term did not rise within %0d cycles",
				name, TEST_CYCLES));
		end
		// Let any late event show up in the monitor
		repeat (4) @(negedge clock);
		@(posedge clock);
		en <= 1'b0;
		@(negedge clock);
		check({name, " emit count"}, 32'(exp_data.size()), 32'(got_data.size()));
		foreach (exp_data[i]) begin
			check($sformatf("%s scalar_data[%0d]", name, i), exp_data[i], got_data[i]);
		end
		check({name, " command count"}, 32'(exp_cmd.size()), 32'(got_cmd.size()));
		foreach (exp_cmd[i]) begin
			check($sformatf("%s v_command[%0d]", name, i), exp_cmd[i], got_cmd[i]);
		end
		check({name, " lane_en"}, 32'(exp_lane), 32'(lane_en));
		check({name, " state"}, 32'(exp_state), 32'(state));
	endtask

	initial begin
		reset    <= 1'b1;
		en       <= 1'b0;
		req_st   <= 1'b0;
		instr_in <= '0;
		void'($urandom(61406));
		for (int i = 0; i < STRAIGHT_TESTS; i++) begin
			gen_straight(int'($urandom_range(8, 24)), 0, 0);
			run_program($sformatf("straight_line_%0d", i));
		end
		for (int i = 0; i < LOOP_TESTS; i++) begin
			gen_loop(int'($urandom_range(1, 40)), int'($urandom_range(1, 5)));
			run_program($sformatf("counting_loop_%0d", i));
		end
		for (int i = 0; i < LANE_TESTS; i++) begin
			gen_straight(int'($urandom_range(8, 24)), 0, 30);
			run_program($sformatf("lane_state_%0d", i));
		end
		for (int i = 0; i < VECTOR_TESTS; i++) begin
			gen_straight(int'($urandom_range(8, 24)), 35, 0);
			run_program($sformatf("vector_cmd_%0d", i));
		end
		$display("All tests passed!");
		$finish;
	end

	// Watchdog sized from the test count
	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		report_failure("watchdog expired before all tests finished");
	end

endmodule

`default_nettype wire

// File: hdl/scalar_unit.sv
/*
 * Scalar unit top level
 * Fetch, decode, two-stage scalar back end and result routing
 */

`default_nettype none

module scalar_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 en,
	input  logic                 req_st,
	input  scalar_pkg::instr_t   instr_in,
	output logic                 ack_st,
	output scalar_pkg::instr_t   v_command,
	output logic                 v_command_valid,
	output scalar_pkg::data_t    scalar_data,
	output logic                 scalar_valid,
	output scalar_pkg::lane_t    lane_en,
	output scalar_pkg::status_t  state,
	output logic                 term
);

	scalar_pkg::instr_t   instr;
	logic                 instr_valid;
	logic                 hold;
	logic                 redirect;
	scalar_pkg::addr_t    redirect_addr;
	logic                 branch_resolved;
	scalar_pkg::reg_idx_t rd_index1;
	scalar_pkg::reg_idx_t rd_index2;
	scalar_pkg::reg_idx_t rd_index3;
	scalar_pkg::data_t    rd_data1;
	scalar_pkg::data_t    rd_data2;
	scalar_pkg::data_t    rd_data3;
	logic                 we;
	scalar_pkg::reg_idx_t wr_index;
	scalar_pkg::data_t    wr_data;
	scalar_pkg::issue_t   issue;
	scalar_pkg::issue_t   exe_issue;
	scalar_pkg::result_t  alu_result;
	scalar_pkg::result_t  wb_result;

	////////////////////////////////////////////////////////////
	// Front end

	fetch_unit u_fetch (
		.clock         (clock),
		.reset         (reset),
		.en            (en),
		.req_st        (req_st),
		.instr_in      (instr_in),
		.ack_st        (ack_st),
		.hold          (hold),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.instr         (instr),
		.instr_valid   (instr_valid)
	);

	decode_unit u_decode (
		.clock           (clock),
		.reset           (reset),
		.en              (en),
		.instr           (instr),
		.instr_valid     (instr_valid),
		.rd_index1       (rd_index1),
		.rd_index2       (rd_index2),
		.rd_index3       (rd_index3),
		.rd_data1        (rd_data1),
		.rd_data2        (rd_data2),
		.rd_data3        (rd_data3),
		.wb_valid        (we),
		.wb_dst          (wr_index),
		.branch_resolved (branch_resolved),
		.redirect        (redirect),
		.hold            (hold),
		.issue           (issue),
		.v_command       (v_command),
		.v_command_valid (v_command_valid),
		.term            (term)
	);

	register_file u_regs (
		.clock     (clock),
		.reset     (reset),
		.rd_index1 (rd_index1),
		.rd_index2 (rd_index2),
		.rd_index3 (rd_index3),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.rd_data3  (rd_data3),
		.we        (we),
		.wr_index  (wr_index),
		.wr_data   (wr_data)
	);

	////////////////////////////////////////////////////////////
	// Scalar back end

	pipe_stage #(.payload_t(scalar_pkg::issue_t)) u_issue_stage (
		.clock (clock),
		.reset (reset),
		.en    (en),
		.d     (issue),
		.q     (exe_issue)
	);

	scalar_alu u_alu (
		.issue  (exe_issue),
		.result (alu_result)
	);

	pipe_stage #(.payload_t(scalar_pkg::result_t)) u_result_stage (
		.clock (clock),
		.reset (reset),
		.en    (en),
		.d     (alu_result),
		.q     (wb_result)
	);

	result_unit u_result (
		.clock           (clock),
		.reset           (reset),
		.en              (en),
		.result          (wb_result),
		.we              (we),
		.wr_index        (wr_index),
		.wr_data         (wr_data),
		.lane_en         (lane_en),
		.scalar_data     (scalar_data),
		.scalar_valid    (scalar_valid),
		.state           (state),
		.redirect        (redirect),
		.redirect_addr   (redirect_addr),
		.branch_resolved (branch_resolved)
	);

endmodule

`default_nettype wire

// File: hdl/result_unit.sv
/*
 * Result unit
 * Routes results to registers, lane enables or the vector data port,
 * keeps the status flags and resolves jumps and branches
 */

`default_nettype none

`include "scalar_macros.svh"

module result_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  en,
	input  scalar_pkg::result_t   result,
	output logic                  we,
	output scalar_pkg::reg_idx_t  wr_index,
	output scalar_pkg::data_t     wr_data,
	output scalar_pkg::lane_t     lane_en,
	output scalar_pkg::data_t     scalar_data,
	output logic                  scalar_valid,
	output scalar_pkg::status_t   state,
	output logic                  redirect,
	output scalar_pkg::addr_t     redirect_addr,
	output logic                  branch_resolved
);

	logic fire;
	logic is_jmp;
	logic is_brc;
	logic sets_flags;

	assign fire       = en && result.valid;
	assign is_jmp     = result.op == scalar_pkg::OP_JMP;
	assign is_brc     = result.op == scalar_pkg::OP_BRC;
	assign sets_flags = !(is_jmp || is_brc || result.op == scalar_pkg::OP_HALT);

	assign we       = fire && result.dst_sel == scalar_pkg::DST_REG;
	assign wr_index = result.dst;
	assign wr_data  = result.value;

	// BRC tests the flag left by the latest CMPLT
	assign branch_resolved = fire && (is_jmp || is_brc);
	assign redirect        = fire && (is_jmp || (is_brc && state.cond));
	assign redirect_addr   = result.target;

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_en      <= '0;
			scalar_valid <= 1'b0;
			state        <= '0;
		end else begin
			scalar_valid <= fire && result.dst_sel == scalar_pkg::DST_VEC;
			if (fire && result.dst_sel == scalar_pkg::DST_LANE) begin
				lane_en <= result.value[`SCALAR_NUM_LANES-1:0];
			end
			if (fire && sets_flags) begin
				state.zero     <= result.value == '0;
				state.negative <= result.value[`SCALAR_DATA_W-1];
				if (result.op == scalar_pkg::OP_CMPLT) begin
					state.cond <= result.cond;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fire && result.dst_sel == scalar_pkg::DST_VEC) begin
			scalar_data <= result.value;
		end
	end

endmodule

`default_nettype wire

// File: execute/scalar_alu.sv
/*
 * Scalar ALU
 * Three-operand arithmetic and logic, signed compare for CMPLT,
 * branch target taken from the instruction constant
 */

`default_nettype none

`include "scalar_macros.svh"

module scalar_alu (
	input  scalar_pkg::issue_t   issue,
	output scalar_pkg::result_t  result
);

	scalar_pkg::data_t                   imm_ext;
	logic [$clog2(`SCALAR_DATA_W)-1:0]   shamt;
	logic                                less;

	assign imm_ext = {{(`SCALAR_DATA_W - 20){1'b0}}, issue.imm};
	assign shamt   = issue.src2[$clog2(`SCALAR_DATA_W)-1:0];
	assign less    = $signed(issue.src1) < $signed(issue.src2);

	always_comb begin
		result.valid   = issue.valid;
		result.op      = issue.op;
		result.dst_sel = issue.dst_sel;
		result.dst     = issue.dst;
		result.cond    = 1'b0;
		result.target  = issue.imm[$bits(scalar_pkg::addr_t)-1:0];
		case (issue.op)
			scalar_pkg::OP_ADD:   result.value = issue.src1 + issue.src2;
			scalar_pkg::OP_SUB:   result.value = issue.src1 - issue.src2;
			scalar_pkg::OP_AND:   result.value = issue.src1 & issue.src2;
			scalar_pkg::OP_OR:    result.value = issue.src1 | issue.src2;
			scalar_pkg::OP_XOR:   result.value = issue.src1 ^ issue.src2;
			scalar_pkg::OP_SHL:   result.value = issue.src1 << shamt;
			scalar_pkg::OP_SHR:   result.value = issue.src1 >> shamt;
			// Product wraps at the data width
			scalar_pkg::OP_MAD:   result.value = issue.src1 * issue.src2 + issue.src3;
			scalar_pkg::OP_LDI:   result.value = imm_ext;
			scalar_pkg::OP_CMPLT: begin
				result.value = {{(`SCALAR_DATA_W - 1){1'b0}}, less};
				result.cond  = less;
			end
			default:              result.value = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: execute/register_file.sv
/*
 * Register file
 * One bank, three combinational read ports, one write port
 */

`default_nettype none

`include "scalar_macros.svh"

module register_file (
	input  logic                  clock,
	input  logic                  reset,
	input  scalar_pkg::reg_idx_t  rd_index1,
	input  scalar_pkg::reg_idx_t  rd_index2,
	input  scalar_pkg::reg_idx_t  rd_index3,
	output scalar_pkg::data_t     rd_data1,
	output scalar_pkg::data_t     rd_data2,
	output scalar_pkg::data_t     rd_data3,
	input  logic                  we,
	input  scalar_pkg::reg_idx_t  wr_index,
	input  scalar_pkg::data_t     wr_data
);

	scalar_pkg::data_t regs [0:`SCALAR_NUM_REGS-1];

	assign rd_data1 = regs[rd_index1];
	assign rd_data2 = regs[rd_index2];
	assign rd_data3 = regs[rd_index3];

	// Written value shows on the read ports from the next cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `SCALAR_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_index] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// File: decode/decode_unit.sv
/*
 * Decode unit
 * Splits fields, reads operands, tracks pending writes in a scoreboard
 * and sends each instruction to the scalar back end or the vector unit
 */

`default_nettype none

`include "scalar_macros.svh"

module decode_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  en,
	input  scalar_pkg::instr_t    instr,
	input  logic                  instr_valid,
	output scalar_pkg::reg_idx_t  rd_index1,
	output scalar_pkg::reg_idx_t  rd_index2,
	output scalar_pkg::reg_idx_t  rd_index3,
	input  scalar_pkg::data_t     rd_data1,
	input  scalar_pkg::data_t     rd_data2,
	input  scalar_pkg::data_t     rd_data3,
	input  logic                  wb_valid,
	input  scalar_pkg::reg_idx_t  wb_dst,
	input  logic                  branch_resolved,
	input  logic                  redirect,
	output logic                  hold,
	output scalar_pkg::issue_t    issue,
	output scalar_pkg::instr_t    v_command,
	output logic                  v_command_valid,
	output logic                  term
);

	logic [`SCALAR_NUM_REGS-1:0] pending;
	logic [`SCALAR_NUM_REGS-1:0] pending_next;
	logic [1:0]                  inflight;
	logic                        branch_wait;
	logic                        is_vec;
	logic                        is_halt;
	logic                        is_branch;
	logic                        reads_ab;
	logic                        hazard;
	logic                        go;
	logic                        mark;

	assign rd_index1 = instr.src1;
	assign rd_index2 = instr.src2;
	assign rd_index3 = instr.src3;

	////////////////////////////////////////////////////////////
	// Field decode and stall

	assign is_vec    = instr.sel_unit;
	assign is_halt   = !is_vec && instr.op == scalar_pkg::OP_HALT;
	assign is_branch = !is_vec && (instr.op == scalar_pkg::OP_JMP ||
		instr.op == scalar_pkg::OP_BRC);
	// Constant forms carry no register sources
	assign reads_ab  = !(instr.op inside {scalar_pkg::OP_LDI, scalar_pkg::OP_JMP,
		scalar_pkg::OP_BRC, scalar_pkg::OP_HALT});

	assign hazard = !is_vec && (
		(reads_ab && (pending[instr.src1] || pending[instr.src2])) ||
		(instr.op == scalar_pkg::OP_MAD && pending[instr.src3]) ||
		(instr.dst_sel == scalar_pkg::DST_REG && pending[instr.dst]));

	// HALT also waits for the back end to drain
	assign go   = instr_valid && !term && !branch_wait && !hazard &&
		!(is_halt && inflight != 2'b00);
	assign hold = term || branch_wait || (instr_valid && !go);
	assign mark = en && issue.valid && instr.dst_sel == scalar_pkg::DST_REG;

	always_comb begin
		issue.valid   = go && !is_vec && !is_halt;
		issue.op      = instr.op;
		issue.dst_sel = instr.dst_sel;
		issue.dst     = instr.dst;
		issue.src1    = rd_data1;
		issue.src2    = rd_data2;
		issue.src3    = rd_data3;
		issue.imm     = instr[19:0];
	end

	always_comb begin
		pending_next = pending;
		if (wb_valid) begin
			pending_next[wb_dst] = 1'b0;
		end
		if (mark) begin
			pending_next[instr.dst] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Control state

	always_ff @(posedge clock) begin
		if (reset) begin
			pending         <= '0;
			inflight        <= 2'b00;
			branch_wait     <= 1'b0;
			v_command_valid <= 1'b0;
			term            <= 1'b0;
		end else begin
			pending         <= pending_next;
			v_command_valid <= en && go && is_vec;
			if (en) begin
				inflight <= {inflight[0], issue.valid};
			end
			if (redirect || branch_resolved) begin
				branch_wait <= 1'b0;
			end else if (en && go && is_branch) begin
				branch_wait <= 1'b1;
			end
			if (en && go && is_halt) begin
				term <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (en && go && is_vec) begin
			v_command <= instr;
		end
	end

	// Every write-back from the result stage retires a marked register
	assert property (@(posedge clock) disable iff (reset) wb_valid |-> pending[wb_dst]);

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
/*
 * Fetch unit
 * Program memory with its store port, the program counter and
 * branch redirect; the memory read is registered
 */

`default_nettype none

`include "scalar_macros.svh"

module fetch_unit (
	input  logic                clock,
	input  logic                reset,
	input  logic                en,
	input  logic                req_st,
	input  scalar_pkg::instr_t  instr_in,
	output logic                ack_st,
	input  logic                hold,
	input  logic                redirect,
	input  scalar_pkg::addr_t   redirect_addr,
	output scalar_pkg::instr_t  instr,
	output logic                instr_valid
);

	scalar_pkg::instr_t imem [0:`SCALAR_IMEM_DEPTH-1];
	scalar_pkg::addr_t  st_addr;
	scalar_pkg::addr_t  pc;
	logic               advance;

	assign advance = en && !hold;

	////////////////////////////////////////////////////////////
	// Program loading

	always_ff @(posedge clock) begin
		if (reset) begin
			st_addr <= '0;
			ack_st  <= 1'b0;
		end else begin
			ack_st <= req_st;
			if (req_st) begin
				st_addr <= st_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_st) begin
			imem[st_addr] <= instr_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Program counter

	// Redirect wins over a held or advancing fetch and drops the word in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= '0;
			instr_valid <= 1'b0;
		end else if (redirect) begin
			pc          <= redirect_addr;
			instr_valid <= 1'b0;
		end else if (advance) begin
			pc          <= pc + 1'b1;
			instr_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (advance && !redirect) begin
			instr <= imem[pc];
		end
	end

	// Loading happens only with execution stopped
	assert property (@(posedge clock) disable iff (reset) req_st |-> !en);

endmodule

`default_nettype wire

// File: hdl/pipe_stage.sv
/*
 * Pipeline stage register
 * Holds one payload of any packed type, advancing only while enabled
 */

`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     en,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clock) begin
		if (reset) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: common/scalar_pkg.sv
/*
 * Scalar unit types
 * Instruction word, opcodes, stage payloads and status flags
 */

`default_nettype none

`include "scalar_macros.svh"

package scalar_pkg;

	typedef logic [`SCALAR_DATA_W-1:0] data_t;
	typedef logic [$clog2(`SCALAR_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [$clog2(`SCALAR_IMEM_DEPTH)-1:0] addr_t;
	typedef logic [`SCALAR_NUM_LANES-1:0] lane_t;
	typedef logic [19:0] imm20_t;

	// MAD computes src1 * src2 + src3
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_SHL   = 4'h5,
		OP_SHR   = 4'h6,
		OP_MAD   = 4'h7,
		OP_LDI   = 4'h8,
		OP_CMPLT = 4'h9,
		OP_JMP   = 4'hA,
		OP_BRC   = 4'hB,
		OP_HALT  = 4'hC
	} op_t;

	// Where a result goes
	typedef enum logic [1:0] {
		DST_NONE = 2'h0,
		DST_REG  = 2'h1,
		DST_LANE = 2'h2,
		DST_VEC  = 2'h3
	} dst_sel_t;

	// LDI, JMP and BRC use the low 20 bits as a constant
	typedef struct packed {
		logic     sel_unit;
		op_t      op;
		dst_sel_t dst_sel;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		reg_idx_t src3;
		logic [4:0] imm;
	} instr_t;

	// Decode to execute
	typedef struct packed {
		logic     valid;
		op_t      op;
		dst_sel_t dst_sel;
		reg_idx_t dst;
		data_t    src1;
		data_t    src2;
		data_t    src3;
		imm20_t   imm;
	} issue_t;

	// Execute to result
	typedef struct packed {
		logic     valid;
		op_t      op;
		dst_sel_t dst_sel;
		reg_idx_t dst;
		data_t    value;
		logic     cond;
		addr_t    target;
	} result_t;

	typedef struct packed {
		logic zero;
		logic negative;
		logic cond;
	} status_t;

endpackage

`default_nettype wire

// File: common/scalar_macros.svh
/*
 * Scalar control processor constants
 * Data width, register count, program memory depth and vector lane count
 */

`ifndef SCALAR_MACROS_SVH
`define SCALAR_MACROS_SVH

// Datapath width in bits
`define SCALAR_DATA_W 32

// Registers in the single bank
`define SCALAR_NUM_REGS 32

// Instruction words held in program memory
`define SCALAR_IMEM_DEPTH 64

// Lanes in the attached vector unit
`define SCALAR_NUM_LANES 8

`endif
